// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module core_tb \
    -Mdir obj_dir -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// File: testbench/core_tb.sv
`timescale 1ns/100ps

module core_tb;

    import core_pkg::*;

    localparam word_t RESET_VECTOR = 64'h1000;
    localparam int    NUM_SETUP    = 8;
    localparam int    NUM_INST     = NUM_SETUP + 200;
    localparam int    TIMEOUT_NS   = NUM_INST * 12 * 20;   // 12 cycles per instruction

    logic        clk, rst_n;
    word_t       if_addr, if_data;
    logic        if_req, if_valid;
    word_t       mem_addr, mem_write_data, mem_read_data;
    logic        mem_read_req, mem_write_req, mem_read_valid, mem_write_ack;
    logic        retire_valid;
    retire_t     retire;
    word_t       debug_pc;
    alu_flags_t  debug_flags;
    logic [31:0] perf_inst_retired, perf_cycles;

    word_t       prog_mem [NUM_INST];   // Fetched program
    word_t       data_mem [256];        // DUT side data memory
    word_t       model_regs [16];
    word_t       model_mem [256];
    alu_flags_t  model_flags;
    logic [31:0] lfsr_state;
    int          errors  = 0;
    int          retired = 0;           // Retirements seen
    int          edges   = 0;           // Rising edges since reset release

    tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

    core_top uut (.*);

    // ==================================================
    // Random source and reference model
    // ==================================================

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);   // One step per bit
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t alu_model(input alu_func_t fn, input word_t a, input word_t b,
                                        output alu_flags_t fl);
        word_t       r;
        logic [64:0] wide;   // Exact signed sum or difference
        fl   = '0;
        wide = '0;
        case (fn)
            FN_ADD: begin
                wide        = {a[63], a} + {b[63], b};
                r           = wide[63:0];
                fl.carry    = (r < a);                  // Wrapped past 2^64
                fl.overflow = (wide[64] != wide[63]);   // Signed result out of range
            end
            FN_SUB: begin
                wide        = {a[63], a} - {b[63], b};
                r           = wide[63:0];
                fl.carry    = (a >= b);                 // No borrow
                fl.overflow = (wide[64] != wide[63]);
            end
            FN_AND:  r = a & b;
            FN_OR:   r = a | b;
            FN_XOR:  r = a ^ b;
            FN_SLL:  r = a << b[5:0];
            FN_SRL:  r = a >> b[5:0];
            FN_SRA:  r = word_t'($signed(a) >>> b[5:0]);
            FN_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: r = '0;
        endcase
        fl.zero     = (r == '0);
        fl.negative = r[63];
        fl.parity   = ^r;
        return r;
    endfunction

    // Runs one instruction on the model state and gives the expected retirement
    function automatic retire_t ref_execute(input word_t inst, input word_t pc);
        retire_t    r;
        opcode_t    op;
        reg_addr_t  rs1, rs2;
        word_t      a, b, imm, addr;
        alu_flags_t fl;
        op   = inst[63:60];
        rs2  = inst[55:52];
        rs1  = inst[51:48];                 // Also the destination
        imm  = {{16{inst[47]}}, inst[47:0]};
        a    = model_regs[rs1];             // r0 stays zero in the model
        b    = model_regs[rs2];
        addr = a + imm;
        r.pc    = pc;
        r.rd    = rs1;
        r.value = '0;
        r.wr    = 1'b0;
        case (op)
            OP_ALU_REG, OP_ALU_IMM: begin
                r.value     = alu_model(inst[59:56], a, (op == OP_ALU_IMM) ? imm : b, fl);
                r.wr        = (rs1 != '0);
                model_flags = fl;
            end
            OP_LOAD: begin
                r.value = model_mem[addr[10:3]];
                r.wr    = (rs1 != '0);
            end
            OP_STORE: begin
                model_mem[addr[10:3]] = b;
                r.value               = b;
            end
            default: r.wr = 1'b0;           // Retires and writes nothing
        endcase
        if (r.wr) begin
            model_regs[rs1] = r.value;
        end
        return r;
    endfunction

    function automatic word_t random_inst();
        opcode_t     op;
        reg_addr_t   rs1, rs2;
        logic [3:0]  fn;
        logic [47:0] imm;
        logic [63:0] bits;
        bits = take_bits(3);
        case (bits[2:0])
            3'd0, 3'd1: op = OP_ALU_REG;
            3'd2, 3'd3: op = OP_ALU_IMM;
            3'd4:       op = OP_LOAD;
            3'd5, 3'd6: op = OP_STORE;
            default:    op = 4'd9;          // Undefined class
        endcase
        bits = take_bits(4);
        fn   = bits[3:0];                   // Includes unused functions
        bits = take_bits(4);
        rs2  = bits[3:0];
        bits = take_bits(4);
        rs1  = bits[3:0];
        if (op == OP_LOAD || op == OP_STORE) begin
            bits = take_bits(6);
            imm  = {40'd0, bits[4:0], 3'd0};   // Small word offsets
            if (bits[5]) begin
                rs1 = '0;                   // Base 0 so loads meet earlier stores
            end
        end else begin
            bits = take_bits(48);
            imm  = bits[47:0];
        end
        return {op, fn, rs2, rs1, imm};
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("FAILED %0t ns: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // ==================================================
    // Memory models
    // ==================================================

    initial begin
        word_t       addr;
        logic [63:0] bits;
        int          idx;
        int          fetches;
        if_valid = 1'b0;
        if_data  = '0;
        fetches  = 0;
        forever begin
            @(negedge clk);
            if (rst_n && if_req) begin
                addr = if_addr;
                check_value("if_addr", addr, RESET_VECTOR + word_t'(fetches * 8));
                fetches++;
                bits = take_bits(2);
                repeat (int'(bits[1:0]) + 1) @(posedge clk);   // 1 to 4 cycles
                #2;
                idx      = int'((addr - RESET_VECTOR) >> 3);
                if_data  = (idx >= 0 && idx < NUM_INST) ? prog_mem[idx] : '0;
                if_valid = 1'b1;
                @(posedge clk);
                #2;
                if_valid = 1'b0;
            end
        end
    end

    initial begin
        word_t       addr, wdata;
        logic        is_write;
        logic [63:0] bits;
        mem_read_data  = '0;
        mem_read_valid = 1'b0;
        mem_write_ack  = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && (mem_read_req || mem_write_req)) begin
                addr     = mem_addr;
                wdata    = mem_write_data;
                is_write = mem_write_req;
                bits     = take_bits(2);
                repeat (int'(bits[1:0]) + 1) @(posedge clk);
                #2;
                if (is_write) begin
                    data_mem[addr[10:3]] = wdata;   // Index bits only
                    mem_write_ack        = 1'b1;
                end else begin
                    mem_read_data  = data_mem[addr[10:3]];
                    mem_read_valid = 1'b1;
                end
                @(posedge clk);
                #2;
                mem_write_ack  = 1'b0;
                mem_read_valid = 1'b0;
            end
        end
    end

    // ==================================================
    // Compare, counters and run control
    // ==================================================

    always @(posedge clk) begin
        if (rst_n) begin
            edges++;
        end
    end

    // Retirement outputs are stable by the falling edge
    always @(negedge clk) begin
        retire_t expected;
        opcode_t op;
        if (rst_n && retire_valid && retired < NUM_INST) begin
            op       = prog_mem[retired][63:60];
            expected = ref_execute(prog_mem[retired], RESET_VECTOR + word_t'(retired * 8));
            check_value("retire.pc", retire.pc, expected.pc);
            check_value("debug_pc", debug_pc, expected.pc);
            check_value("retire.rd", 64'(retire.rd), 64'(expected.rd));
            check_value("retire.wr", 64'(retire.wr), 64'(expected.wr));
            if (op == OP_ALU_REG || op == OP_ALU_IMM || op == OP_LOAD || op == OP_STORE) begin
                check_value("retire.value", retire.value, expected.value);
            end
            check_value("debug_flags", 64'(debug_flags), 64'(model_flags));
            // Stored words land at mem_addr with mem_write_data
            if (op == OP_STORE) begin
                for (int i = 0; i < 256; i++) begin
                    check_value($sformatf("mem_write_data at index %0d", i),
                                data_mem[i], model_mem[i]);
                end
            end
            retired++;
        end
    end

    initial begin
        logic [63:0] bits;
        lfsr_state  = 32'hf948;
        model_flags = '0;
        for (int i = 0; i < 256; i++) begin
            data_mem[i]  = '0;
            model_mem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        // Setup loads r1..r8 with constants
        for (int i = 0; i < NUM_SETUP; i++) begin
            bits        = take_bits(48);
            prog_mem[i] = {OP_ALU_IMM, FN_ADD, 4'd0, 4'(i + 1), bits[47:0]};
        end
        for (int i = NUM_SETUP; i < NUM_INST; i++) begin
            prog_mem[i] = random_inst();
        end
        wait (retired == NUM_INST);
        @(posedge clk);
        #2;
        check_value("perf_inst_retired", 64'(perf_inst_retired), 64'(retired));
        check_value("perf_cycles", 64'(perf_cycles), 64'(edges));
        $display("Errors: %0d in %0d retired instructions", errors, retired);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: only %0d of %0d instructions retired after %0d ns",
                 retired, NUM_INST, TIMEOUT_NS);
        $display("Errors: %0d in %0d retired instructions", errors, retired);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release a little after the edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// File: verilog.f
verilog/core_pkg.sv
verilog/core_regfile.sv
verilog/core_decode.sv
verilog/core_execute.sv
verilog/core_result.sv
verilog/core_top.sv
testbench/tb_clock_gen.sv
testbench/core_tb.sv

// File: verilog/core_decode.sv
`timescale 1ns/100ps

module core_decode #(
    parameter core_pkg::word_t RESET_VECTOR = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Instruction fetch port
    output core_pkg::word_t         if_addr,
    output logic                    if_req,
    input  core_pkg::word_t         if_data,
    input  logic                    if_valid,

    input  logic                    retire_valid,   // Previous instruction done

    // Register file read ports
    output core_pkg::reg_addr_t     rd_addr_a,
    output core_pkg::reg_addr_t     rd_addr_b,
    input  core_pkg::word_t         rd_data_a,
    input  core_pkg::word_t         rd_data_b,

    output logic                    dec_valid,
    output core_pkg::decoded_inst_t dec,
    output core_pkg::word_t         debug_pc
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        FETCH,        // First fetch after reset
        WAIT_INST,    // Request out, waiting for if_valid
        WAIT_RETIRE   // Instruction in flight
    } fetch_state_t;

    fetch_state_t state;
    word_t        pc;          // Next fetch address
    logic         inst_take;   // Instruction word arrives

    assign inst_take = (state == WAIT_INST) && if_valid;

    // Operands come straight from the fetched word
    assign rd_addr_a = if_data[51:48];   // rs1
    assign rd_addr_b = if_data[55:52];   // rs2

    // ==================================================
    // Fetch sequencing
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FETCH;
            pc        <= RESET_VECTOR;
            if_addr   <= RESET_VECTOR;
            if_req    <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            if_req    <= 1'b0;       // Single-cycle pulses
            dec_valid <= 1'b0;
            case (state)
                FETCH: begin
                    if_req  <= 1'b1;
                    if_addr <= pc;
                    state   <= WAIT_INST;
                end
                WAIT_INST: begin
                    if (if_valid) begin
                        dec_valid <= 1'b1;
                        pc        <= pc + word_t'(8);   // No branches
                        state     <= WAIT_RETIRE;
                    end
                end
                WAIT_RETIRE: begin
                    if (retire_valid) begin   // Fetch in the following cycle
                        if_req  <= 1'b1;
                        if_addr <= pc;
                        state   <= WAIT_INST;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // ==================================================
    // Field decode and operand sample
    // ==================================================

    always_ff @(posedge clk) begin
        if (inst_take) begin
            dec.pc      <= pc;
            dec.opcode  <= if_data[63:60];
            dec.funct   <= if_data[59:56];
            dec.rd      <= if_data[51:48];   // Destination is the rs1 field
            dec.rs1_val <= rd_data_a;
            dec.rs2_val <= rd_data_b;
            dec.imm     <= {{(XLEN-48){if_data[47]}}, if_data[47:0]};
        end
    end

    assign debug_pc = dec.pc;   // Held until the next decode

    // One request per instruction
    a_if_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        if_req |=> !if_req);

    // Environment answers only an open fetch
    a_if_valid_state: assert property (@(posedge clk) disable iff (!rst_n)
        if_valid |-> state == WAIT_INST);

endmodule

// File: verilog/core_execute.sv
`timescale 1ns/100ps

module core_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dec_valid,
    input  core_pkg::decoded_inst_t dec,
    output logic                    exe_valid,
    output core_pkg::exec_result_t  exe
);

    import core_pkg::*;

    word_t         op_a, op_b;
    word_t         alu_val;
    alu_flags_t    flags;
    logic [5:0]    shamt;          // Shift amount
    logic [XLEN:0] sum_ext;        // Carry in top bit
    logic [XLEN:0] diff_ext;       // a + ~b + 1 with no-borrow in the top bit

    // ==================================================
    // Operand select and ALU
    // ==================================================

    assign op_a  = dec.rs1_val;
    assign op_b  = (dec.opcode == OP_ALU_IMM) ? dec.imm : dec.rs2_val;
    assign shamt = op_b[5:0];

    assign sum_ext  = {1'b0, op_a} + {1'b0, op_b};
    assign diff_ext = {1'b0, op_a} + {1'b0, ~op_b} + (XLEN+1)'(1);

    always_comb begin
        alu_val = '0;   // Unknown functions give zero
        flags   = '0;
        case (dec.funct)
            FN_ADD: begin
                alu_val        = sum_ext[XLEN-1:0];
                flags.carry    = sum_ext[XLEN];
                flags.overflow = (op_a[XLEN-1] == op_b[XLEN-1]) &&
                                 (sum_ext[XLEN-1] != op_a[XLEN-1]);
            end
            FN_SUB: begin
                alu_val        = diff_ext[XLEN-1:0];
                flags.carry    = diff_ext[XLEN];
                flags.overflow = (op_a[XLEN-1] != op_b[XLEN-1]) &&
                                 (diff_ext[XLEN-1] != op_a[XLEN-1]);
            end
            FN_AND: alu_val = op_a & op_b;
            FN_OR:  alu_val = op_a | op_b;
            FN_XOR: alu_val = op_a ^ op_b;
            FN_SLL: alu_val = op_a << shamt;
            FN_SRL: alu_val = op_a >> shamt;
            FN_SRA: alu_val = $signed(op_a) >>> shamt;
            FN_SLT: alu_val = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            default: alu_val = '0;
        endcase

        // Result flags for every function
        flags.zero     = (alu_val == '0);
        flags.negative = alu_val[XLEN-1];
        flags.parity   = ^alu_val;
    end

    // ==================================================
    // Stage register
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;   // One cycle behind decode
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe.pc         <= dec.pc;
            exe.opcode     <= dec.opcode;
            exe.rd         <= dec.rd;
            exe.alu_val    <= alu_val;
            exe.mem_addr   <= dec.rs1_val + dec.imm;   // Load/store address
            exe.store_data <= dec.rs2_val;
            exe.flags      <= flags;
        end
    end

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

    // ==================================================
    // Widths
    // ==================================================

    parameter int XLEN     = 64;     // Data and address width
    parameter int NUM_REGS = 16;     // General registers

    typedef logic [XLEN-1:0] word_t;       // Data, address, PC
    typedef logic [3:0]      reg_addr_t;   // Register index
    typedef logic [3:0]      opcode_t;     // Instruction class
    typedef logic [3:0]      alu_func_t;   // ALU operation

    // ==================================================
    // Opcodes and ALU functions
    // ==================================================

    parameter opcode_t OP_ALU_REG = 4'd1;  // rs1 op rs2
    parameter opcode_t OP_ALU_IMM = 4'd2;  // rs1 op imm
    parameter opcode_t OP_LOAD    = 4'd4;
    parameter opcode_t OP_STORE   = 4'd5;

    parameter alu_func_t FN_ADD = 4'd0;
    parameter alu_func_t FN_SUB = 4'd1;
    parameter alu_func_t FN_AND = 4'd2;
    parameter alu_func_t FN_OR  = 4'd3;
    parameter alu_func_t FN_XOR = 4'd4;
    parameter alu_func_t FN_SLL = 4'd5;    // Shift by b[5:0]
    parameter alu_func_t FN_SRL = 4'd6;
    parameter alu_func_t FN_SRA = 4'd7;
    parameter alu_func_t FN_SLT = 4'd8;    // Signed compare, 1 or 0

    // ==================================================
    // Stage structs
    // ==================================================

    typedef struct packed {
        logic negative;    // Result bit 63
        logic overflow;    // Add/sub only
        logic carry;       // Sub carry means no borrow
        logic zero;
        logic parity;      // XOR of all result bits
    } alu_flags_t;

    // Decode to execute
    typedef struct packed {
        word_t     pc;
        opcode_t   opcode;
        alu_func_t funct;
        reg_addr_t rd;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;        // Sign-extended
    } decoded_inst_t;

    // Execute to result
    typedef struct packed {
        word_t      pc;
        opcode_t    opcode;
        reg_addr_t  rd;
        word_t      alu_val;
        word_t      mem_addr;    // rs1 + imm
        word_t      store_data;  // rs2 value
        alu_flags_t flags;
    } exec_result_t;

    // Retirement record
    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     value;
        logic      wr;       // A register was written
    } retire_t;

endpackage

// File: verilog/core_regfile.sv
`timescale 1ns/100ps

module core_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::reg_addr_t rd_addr_a,
    input  core_pkg::reg_addr_t rd_addr_b,
    output core_pkg::word_t     rd_data_a,
    output core_pkg::word_t     rd_data_b,
    input  logic                wr_en,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::word_t     wr_data
);

    import core_pkg::*;

    word_t regs [NUM_REGS];

    // Single write port, r0 stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational reads
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// File: verilog/core_result.sv
`timescale 1ns/100ps

module core_result (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   exe_valid,
    input  core_pkg::exec_result_t exe,

    // Data port
    output core_pkg::word_t        mem_addr,
    output core_pkg::word_t        mem_write_data,
    output logic                   mem_read_req,
    output logic                   mem_write_req,
    input  core_pkg::word_t        mem_read_data,
    input  logic                   mem_read_valid,
    input  logic                   mem_write_ack,

    // Register write-back
    output logic                   wr_en,
    output core_pkg::reg_addr_t    wr_addr,
    output core_pkg::word_t        wr_data,

    output logic                   retire_valid,
    output core_pkg::retire_t      retire,
    output core_pkg::alu_flags_t   debug_flags,
    output logic [31:0]            perf_inst_retired,
    output logic [31:0]            perf_cycles
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_WAIT,    // Read request out
        STORE_WAIT    // Write request out
    } mem_state_t;

    mem_state_t state;
    logic       is_alu;   // Register or immediate ALU form

    assign is_alu = (exe.opcode == OP_ALU_REG) || (exe.opcode == OP_ALU_IMM);

    // ==================================================
    // Memory sequencing and retirement
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            mem_read_req  <= 1'b0;
            mem_write_req <= 1'b0;
            retire_valid  <= 1'b0;
            retire.wr     <= 1'b0;
            debug_flags   <= '0;
        end else begin
            mem_read_req  <= 1'b0;   // All strobes are pulses
            mem_write_req <= 1'b0;
            retire_valid  <= 1'b0;
            case (state)
                IDLE: begin
                    if (exe_valid) begin
                        if (exe.opcode == OP_LOAD) begin
                            mem_read_req <= 1'b1;
                            mem_addr     <= exe.mem_addr;
                            state        <= LOAD_WAIT;
                        end else if (exe.opcode == OP_STORE) begin
                            mem_write_req  <= 1'b1;
                            mem_addr       <= exe.mem_addr;
                            mem_write_data <= exe.store_data;   // All bytes
                            state          <= STORE_WAIT;
                        end else begin
                            retire_valid <= 1'b1;
                            retire.pc    <= exe.pc;
                            retire.rd    <= exe.rd;
                            retire.value <= exe.alu_val;
                            retire.wr    <= is_alu && (exe.rd != '0);   // r0 never written
                            if (is_alu) begin
                                debug_flags <= exe.flags;
                            end
                        end
                    end
                end
                LOAD_WAIT: begin
                    if (mem_read_valid) begin
                        retire_valid <= 1'b1;
                        retire.pc    <= exe.pc;       // exe held until next decode
                        retire.rd    <= exe.rd;
                        retire.value <= mem_read_data;
                        retire.wr    <= (exe.rd != '0);
                        state        <= IDLE;
                    end
                end
                STORE_WAIT: begin
                    if (mem_write_ack) begin
                        retire_valid <= 1'b1;
                        retire.pc    <= exe.pc;
                        retire.rd    <= exe.rd;
                        retire.value <= exe.store_data;
                        retire.wr    <= 1'b0;         // Store writes no register
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Write lands on the edge that ends the retire cycle
    assign wr_en   = retire_valid && retire.wr;
    assign wr_addr = retire.rd;
    assign wr_data = retire.value;

    // ==================================================
    // Performance counters
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            perf_cycles       <= '0;
            perf_inst_retired <= '0;
        end else begin
            perf_cycles <= perf_cycles + 32'd1;
            if (retire_valid) begin
                perf_inst_retired <= perf_inst_retired + 32'd1;
            end
        end
    end

    a_req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read_req && mem_write_req));

    // No retirement out of a wait state without its answer
    a_retire_answered: assert property (@(posedge clk) disable iff (!rst_n)
        (state != IDLE && !mem_read_valid && !mem_write_ack) |=> !retire_valid);

endmodule

// File: verilog/core_top.sv
`timescale 1ns/100ps

module core_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // Instruction fetch port
    output core_pkg::word_t      if_addr,
    output logic                 if_req,
    input  core_pkg::word_t      if_data,
    input  logic                 if_valid,

    // Data port
    output core_pkg::word_t      mem_addr,
    output core_pkg::word_t      mem_write_data,
    output logic                 mem_read_req,
    output logic                 mem_write_req,
    input  core_pkg::word_t      mem_read_data,
    input  logic                 mem_read_valid,
    input  logic                 mem_write_ack,

    // Retirement
    output logic                 retire_valid,
    output core_pkg::retire_t    retire,

    // Debug and performance
    output core_pkg::word_t      debug_pc,
    output core_pkg::alu_flags_t debug_flags,
    output logic [31:0]          perf_inst_retired,
    output logic [31:0]          perf_cycles
);

    import core_pkg::*;

    localparam word_t RESET_VECTOR = 64'h1000;   // First fetch address

    // ==================================================
    // Stage wiring
    // ==================================================

    reg_addr_t     rd_addr_a, rd_addr_b;   // Operand read addresses
    word_t         rd_data_a, rd_data_b;
    logic          dec_valid;
    decoded_inst_t dec;
    logic          exe_valid;
    exec_result_t  exe;
    logic          wr_en;                  // Write-back port
    reg_addr_t     wr_addr;
    word_t         wr_data;

    core_decode #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_addr      (if_addr),
        .if_req       (if_req),
        .if_data      (if_data),
        .if_valid     (if_valid),
        .retire_valid (retire_valid),    // Starts next fetch
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .debug_pc     (debug_pc)
    );

    core_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    core_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .exe_valid (exe_valid),
        .exe       (exe)
    );

    core_result u_result (
        .clk               (clk),
        .rst_n             (rst_n),
        .exe_valid         (exe_valid),
        .exe               (exe),
        .mem_addr          (mem_addr),
        .mem_write_data    (mem_write_data),
        .mem_read_req      (mem_read_req),
        .mem_write_req     (mem_write_req),
        .mem_read_data     (mem_read_data),
        .mem_read_valid    (mem_read_valid),
        .mem_write_ack     (mem_write_ack),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .retire_valid      (retire_valid),
        .retire            (retire),
        .debug_flags       (debug_flags),
        .perf_inst_retired (perf_inst_retired),
        .perf_cycles       (perf_cycles)
    );

endmodule
